//--- hdl/memSysPkg.sv
package memSysPkg;

   // Data word and byte address
   typedef logic [15:0] wordT;
   typedef logic [15:0] addrT;

   // ##################################################
   // Address split and line geometry
   // ##################################################

   // Tag | index | byte offset
   localparam int tagW    = 5;
   localparam int indexW  = 8;
   localparam int offsetW = 3;

   // Word select within a line, also the bank select
   localparam int wordSelW = offsetW - 1;
   localparam int numBanks = 2 ** wordSelW;

   // Word address seen by the banks
   localparam int wordAddrW = tagW + indexW + wordSelW;

   // One tag-array entry
   typedef struct packed {
      logic            valid;
      logic            dirty;
      logic [tagW-1:0] tag;
   } tagEntryT;

   // One request toward the banks
   typedef struct packed {
      logic                 rd;
      logic                 wr;
      logic [wordAddrW-1:0] addr;
      wordT                 wData;
   } memReqT;

   // Controller states
   typedef enum logic [3:0] {
      IDLE,
      COMP,
      EVICT_ISSUE,
      EVICT_WAIT,
      FILL_ISSUE,
      FILL_WAIT,
      FILL_WRITE,
      RETRY,
      DONE_ST
   } ctrlStateT;

endpackage

//--- hdl/syncRam.sv
`timescale 1ns/10ps

module syncRam #(
   parameter type payloadT = logic [15:0],
   parameter int depthLog2 = 8
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 en,
   input  logic                 we,
   input  logic [depthLog2-1:0] addr,
   input  payloadT              wData,
   output payloadT              rData
);

   // Storage array
   payloadT mem [2**depthLog2];

   always_ff @(posedge clk) begin
      if (en && we) begin
         mem[addr] <= wData;
      end
   end

   // Registered read
   // Old contents come back on a same-cycle write
   always_ff @(posedge clk) begin
      if (rst) begin
         rData <= '0;
      end else if (en) begin
         rData <= mem[addr];
      end
   end

endmodule

//--- hdl/cacheStore.sv
`timescale 1ns/10ps

module cacheStore (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          enable,
   input  logic                          compare,
   input  logic                          write,
   input  logic [memSysPkg::tagW-1:0]    tagIn,
   input  logic [memSysPkg::indexW-1:0]  index,
   input  logic [memSysPkg::offsetW-1:0] offset,
   input  memSysPkg::wordT               dataIn,
   input  logic                          setDirty,
   output logic                          hit,
   output logic                          dirty,
   output logic                          valid,
   output logic [memSysPkg::tagW-1:0]    tagOut,
   output memSysPkg::wordT               dataOut
);
   import memSysPkg::*;

   // Line valid bits kept in flops so reset clears them
   logic [2**indexW-1:0] validVec;
   logic                 validQ;
   tagEntryT             tagQ;
   tagEntryT             tagWr;
   logic                 tagWe;
   logic                 dataWe;
   logic                 lastWord;
   logic [indexW+wordSelW-1:0] dataAddr;

   // Word 3 of a line closes a refill
   assign lastWord = offset[offsetW-1:1] == '1;
   assign dataAddr = {index, offset[offsetW-1:1]};

   // Compare mode writes only on a hit
   assign dataWe = write && (!compare || hit);

   // Tag update
   // compare hit marks dirty, last fill word installs a clean line
   assign tagWe = write && (compare ? hit : lastWord);
   assign tagWr = '{valid: 1'b1, dirty: compare && setDirty, tag: tagIn};

   always_ff @(posedge clk) begin
      if (rst) begin
         validVec <= '0;
         validQ   <= 1'b0;
      end else if (enable) begin
         validQ <= validVec[index];
         if (tagWe) begin
            validVec[index] <= 1'b1;
         end
      end
   end

   syncRam #(
      .payloadT  (tagEntryT),
      .depthLog2 (indexW)
   ) uTagRam (
      .clk   (clk),
      .rst   (rst),
      .en    (enable),
      .we    (tagWe),
      .addr  (index),
      .wData (tagWr),
      .rData (tagQ)
   );

   syncRam #(
      .payloadT  (wordT),
      .depthLog2 (indexW + wordSelW)
   ) uDataRam (
      .clk   (clk),
      .rst   (rst),
      .en    (enable),
      .we    (dataWe),
      .addr  (dataAddr),
      .wData (dataIn),
      .rData (dataOut)
   );

   // Status of the line read last cycle
   assign valid  = validQ && tagQ.valid;
   assign dirty  = tagQ.dirty;
   assign tagOut = tagQ.tag;
   assign hit    = valid && (tagQ.tag == tagIn);

   // Controller only writes in compare mode after seeing a hit
   compareWriteHit: assert property (@(posedge clk) disable iff (rst)
      (enable && compare && write) |-> hit);

endmodule

//--- hdl/fourBankMem.sv
`timescale 1ns/10ps

module fourBankMem #(
   parameter int memReadLatency = 2,
   parameter int bankBusyCycles = 4,
   parameter int bankDepthLog2  = 13
) (
   input  logic              clk,
   input  logic              rst,
   input  memSysPkg::memReqT req,
   output memSysPkg::wordT   rdData,
   output logic              rdValid,
   output logic              stall
);
   import memSysPkg::*;

   localparam int cntW = $clog2(bankBusyCycles + 1);

   // Read word plus its valid flag
   typedef struct packed {
      logic vld;
      wordT data;
   } rdSlotT;

   logic [numBanks-1:0] bankBusy;
   wordT                bankData [numBanks];
   logic [wordSelW-1:0] bankSel;
   logic [wordSelW-1:0] bankQ;
   logic                access;
   logic                rdQ;
   rdSlotT              headSlot;
   rdSlotT              outSlot;

   // Low word-address bits pick the bank
   assign bankSel = req.addr[wordSelW-1:0];
   assign stall   = bankBusy[bankSel];
   // Busy bank drops the access
   assign access  = (req.rd || req.wr) && !stall;

   // ##################################################
   // Banks and busy windows
   // ##################################################
   for (genvar b = 0; b < numBanks; b++) begin : gBank
      logic            selBank;
      logic [cntW-1:0] busyCnt;

      assign selBank     = access && (bankSel == wordSelW'(b));
      assign bankBusy[b] = busyCnt != '0;

      // Counts down the cycles after an access
      always_ff @(posedge clk) begin
         if (rst) begin
            busyCnt <= '0;
         end else if (selBank) begin
            busyCnt <= cntW'(bankBusyCycles - 1);
         end else if (busyCnt != '0) begin
            busyCnt <= busyCnt - 1'b1;
         end
      end

      syncRam #(
         .payloadT  (wordT),
         .depthLog2 (bankDepthLog2)
      ) uBankRam (
         .clk   (clk),
         .rst   (rst),
         .en    (selBank),
         .we    (req.wr),
         .addr  (req.addr[wordSelW +: bankDepthLog2]),
         .wData (req.wData),
         .rData (bankData[b])
      );
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rdQ <= 1'b0;
      end else begin
         rdQ <= req.rd && access;
      end
   end

   always_ff @(posedge clk) begin
      bankQ <= bankSel;
   end

   // RAM register is the first latency stage
   assign headSlot = '{vld: rdQ, data: bankData[bankQ]};

   if (memReadLatency == 1) begin : gDirect
      assign outSlot = headSlot;
   end else begin : gDelay
      rdSlotT pipe [memReadLatency-1];

      // Several reads may be in the line at once
      always_ff @(posedge clk) begin
         pipe[0] <= headSlot;
         for (int i = 1; i < memReadLatency - 1; i++) begin
            pipe[i] <= pipe[i-1];
         end
         if (rst) begin
            for (int i = 0; i < memReadLatency - 1; i++) begin
               pipe[i].vld <= 1'b0;
            end
         end
      end

      assign outSlot = pipe[memReadLatency-2];
   end

   assign rdData  = outSlot.data;
   assign rdValid = outSlot.vld;

   // Round-robin issue keeps every bank out of its busy window
   noBusyAccess: assert property (@(posedge clk) disable iff (rst)
      (req.rd || req.wr) |-> !stall);

endmodule

//--- hdl/cacheCtrl.sv
`timescale 1ns/10ps

module cacheCtrl (
   input  logic                          clk,
   input  logic                          rst,
   input  memSysPkg::addrT               Addr,
   input  memSysPkg::wordT               DataIn,
   input  logic                          Rd,
   input  logic                          Wr,
   output logic                          cacheEnable,
   output logic                          cacheCompare,
   output logic                          cacheWrite,
   output logic [memSysPkg::indexW-1:0]  cacheIndex,
   output logic [memSysPkg::offsetW-1:0] cacheOffset,
   output logic [memSysPkg::tagW-1:0]    cacheTagIn,
   output memSysPkg::wordT               cacheDataIn,
   output logic                          cacheSetDirty,
   input  logic                          cacheHit,
   input  logic                          cacheDirty,
   input  logic                          cacheValid,
   input  logic [memSysPkg::tagW-1:0]    cacheTagOut,
   input  memSysPkg::wordT               cacheDataOut,
   output memSysPkg::memReqT             memReq,
   input  memSysPkg::wordT               memRdData,
   input  logic                          memRdValid,
   input  logic                          memStall,
   output memSysPkg::wordT               DataOut,
   output logic                          Done,
   output logic                          Stall,
   output logic                          cacheHitOut,
   output logic                          err
);
   import memSysPkg::*;

   ctrlStateT           state;
   ctrlStateT           nextState;
   addrT                reqAddr;
   addrT                curAddr;
   wordT                reqData;
   wordT                dataQ;
   logic                reqWr;
   logic                hitQ;
   logic                errQ;
   logic                accept;
   logic                badReq;
   logic [wordSelW-1:0] issueCnt;
   logic [wordSelW-1:0] retCnt;

   // New request only while idle
   assign accept = (state == IDLE) && (Rd || Wr);
   // Odd address or both strobes
   assign badReq = Addr[0] || (Rd && Wr);

   // ##################################################
   // Next state
   // ##################################################
   always_comb begin
      nextState = state;
      case (state)
         IDLE: begin
            if (accept) begin
               nextState = badReq ? DONE_ST : COMP;
            end
         end
         COMP: begin
            if (cacheHit) begin
               nextState = DONE_ST;
            end else if (cacheValid && cacheDirty) begin
               nextState = EVICT_ISSUE;
            end else begin
               nextState = FILL_ISSUE;
            end
         end
         EVICT_ISSUE: begin
            if (issueCnt == '1) begin
               nextState = EVICT_WAIT;
            end
         end
         EVICT_WAIT:  nextState = FILL_ISSUE;
         FILL_ISSUE: begin
            if (issueCnt == '1) begin
               nextState = FILL_WAIT;
            end
         end
         FILL_WAIT: begin
            // Last refill word arriving
            if (memRdValid && retCnt == '1) begin
               nextState = FILL_WRITE;
            end
         end
         FILL_WRITE:  nextState = RETRY;
         RETRY:       nextState = DONE_ST;
         DONE_ST:     nextState = IDLE;
         default:     nextState = IDLE;
      endcase
   end

   // ##################################################
   // Cache and bank drive
   // ##################################################

   // Raw address while idle, latched one after
   assign curAddr    = (state == IDLE) ? Addr : reqAddr;
   assign cacheIndex = curAddr[offsetW +: indexW];
   assign cacheTagIn = curAddr[offsetW+indexW +: tagW];

   always_comb begin
      cacheEnable   = 1'b0;
      cacheCompare  = 1'b0;
      cacheWrite    = 1'b0;
      cacheSetDirty = 1'b0;
      cacheOffset   = curAddr[offsetW-1:0];
      cacheDataIn   = reqData;
      memReq        = '0;
      case (state)
         IDLE: begin
            // Tag and word read for next cycle's compare
            cacheEnable  = Rd || Wr;
            cacheCompare = 1'b1;
         end
         COMP, RETRY: begin
            cacheEnable   = 1'b1;
            cacheCompare  = 1'b1;
            cacheWrite    = reqWr && cacheHit;
            cacheSetDirty = reqWr;
         end
         EVICT_ISSUE, EVICT_WAIT: begin
            // Read word issueCnt
            cacheEnable = (state == EVICT_ISSUE);
            cacheOffset = {issueCnt, 1'b0};
            // Write back the word read last cycle
            memReq.wr    = (state == EVICT_WAIT) || (issueCnt != '0);
            memReq.addr  = {cacheTagOut, reqAddr[offsetW +: indexW], retCnt};
            memReq.wData = cacheDataOut;
         end
         FILL_ISSUE, FILL_WAIT: begin
            if (state == FILL_ISSUE) begin
               memReq.rd   = 1'b1;
               memReq.addr = {reqAddr[offsetW+indexW +: tagW],
                              reqAddr[offsetW +: indexW], issueCnt};
            end
            // Each returning word goes straight into the line
            if (memRdValid) begin
               cacheEnable = 1'b1;
               cacheWrite  = 1'b1;
               cacheOffset = {retCnt, 1'b0};
               cacheDataIn = memRdData;
            end
         end
         FILL_WRITE: begin
            // Re-read the refilled line for the retry
            cacheEnable = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // ##################################################
   // State, counters and reply
   // ##################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         issueCnt <= '0;
         retCnt   <= '0;
         reqWr    <= 1'b0;
         hitQ     <= 1'b0;
         errQ     <= 1'b0;
      end else begin
         state <= nextState;
         if (accept) begin
            reqWr <= Wr;
            hitQ  <= 1'b0;
            errQ  <= badReq;
         end
         // First compare decides the reported hit
         if (state == COMP) begin
            hitQ     <= cacheHit;
            issueCnt <= '0;
            retCnt   <= '0;
         end
         if (state == EVICT_ISSUE || state == FILL_ISSUE) begin
            issueCnt <= issueCnt + 1'b1;
         end
         // Bank writes back or refill words landed
         if (memReq.wr || (cacheWrite && !cacheCompare)) begin
            retCnt <= retCnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         reqAddr <= Addr;
         reqData <= DataIn;
      end
      if (state == COMP || state == RETRY) begin
         dataQ <= cacheDataOut;
      end
   end

   assign Done        = (state == DONE_ST);
   assign Stall       = (state != IDLE);
   assign DataOut     = dataQ;
   assign cacheHitOut = Done && hitQ;
   assign err         = Done && errQ;

   donePulse: assert property (@(posedge clk) disable iff (rst)
      Done |=> !Done);

   stallReleased: assert property (@(posedge clk) disable iff (rst)
      Done |=> !Stall);

   noIssueOnStall: assert property (@(posedge clk) disable iff (rst)
      (memReq.rd || memReq.wr) |-> !memStall);

endmodule

//--- hdl/memSystem.sv
`timescale 1ns/10ps

module memSystem #(
   parameter int memReadLatency = 2,
   parameter int bankBusyCycles = 4,
   parameter int bankDepthLog2  = 13
) (
   input  logic            clk,
   input  logic            rst,
   input  memSysPkg::addrT Addr,
   input  memSysPkg::wordT DataIn,
   input  logic            Rd,
   input  logic            Wr,
   output memSysPkg::wordT DataOut,
   output logic            Done,
   output logic            Stall,
   output logic            cacheHitOut,
   output logic            err
);
   import memSysPkg::*;

   // Controller to cache store
   logic                 cacheEnable;
   logic                 cacheCompare;
   logic                 cacheWrite;
   logic                 cacheSetDirty;
   logic [indexW-1:0]    cacheIndex;
   logic [offsetW-1:0]   cacheOffset;
   logic [tagW-1:0]      cacheTagIn;
   wordT                 cacheDataIn;

   // Cache store to controller
   logic                 cacheHit;
   logic                 cacheDirty;
   logic                 cacheValid;
   logic [tagW-1:0]      cacheTagOut;
   wordT                 cacheDataOut;

   // Bank side
   memReqT               memReq;
   wordT                 memRdData;
   logic                 memRdValid;
   logic                 memStall;

   cacheCtrl uCtrl (
      .clk           (clk),
      .rst           (rst),
      .Addr          (Addr),
      .DataIn        (DataIn),
      .Rd            (Rd),
      .Wr            (Wr),
      .cacheEnable   (cacheEnable),
      .cacheCompare  (cacheCompare),
      .cacheWrite    (cacheWrite),
      .cacheIndex    (cacheIndex),
      .cacheOffset   (cacheOffset),
      .cacheTagIn    (cacheTagIn),
      .cacheDataIn   (cacheDataIn),
      .cacheSetDirty (cacheSetDirty),
      .cacheHit      (cacheHit),
      .cacheDirty    (cacheDirty),
      .cacheValid    (cacheValid),
      .cacheTagOut   (cacheTagOut),
      .cacheDataOut  (cacheDataOut),
      .memReq        (memReq),
      .memRdData     (memRdData),
      .memRdValid    (memRdValid),
      .memStall      (memStall),
      .DataOut       (DataOut),
      .Done          (Done),
      .Stall         (Stall),
      .cacheHitOut   (cacheHitOut),
      .err           (err)
   );

   cacheStore uCache (
      .clk      (clk),
      .rst      (rst),
      .enable   (cacheEnable),
      .compare  (cacheCompare),
      .write    (cacheWrite),
      .tagIn    (cacheTagIn),
      .index    (cacheIndex),
      .offset   (cacheOffset),
      .dataIn   (cacheDataIn),
      .setDirty (cacheSetDirty),
      .hit      (cacheHit),
      .dirty    (cacheDirty),
      .valid    (cacheValid),
      .tagOut   (cacheTagOut),
      .dataOut  (cacheDataOut)
   );

   fourBankMem #(
      .memReadLatency (memReadLatency),
      .bankBusyCycles (bankBusyCycles),
      .bankDepthLog2  (bankDepthLog2)
   ) uMem (
      .clk     (clk),
      .rst     (rst),
      .req     (memReq),
      .rdData  (memRdData),
      .rdValid (memRdValid),
      .stall   (memStall)
   );

endmodule

//--- dv/memSystemTb.sv
`timescale 1ns/10ps

module memSystemTb;
   import memSysPkg::*;

   localparam int numReqs   = 300;
   // Bound on cycles from acceptance to Done
   localparam int doneBound = 40;
   localparam int maxCycles = numReqs * doneBound;

   logic clk;
   logic rst;
   addrT Addr;
   wordT DataIn;
   logic Rd;
   logic Wr;
   wordT DataOut;
   logic Done;
   logic Stall;
   logic cacheHitOut;
   logic err;

   // Shadow of main memory, one entry per word address
   wordT shadow [2**wordAddrW];

   // Direct-mapped cache model
   logic [tagW-1:0] modelTag   [2**indexW];
   logic            modelValid [2**indexW];
   logic            modelDirty [2**indexW];

   integer seed;
   int     errors;
   int     cycleCount;
   int     hits;
   int     misses;
   int     evictions;
   int     badReqs;

   memSystem #(
      .memReadLatency (2),
      .bankBusyCycles (4),
      .bankDepthLog2  (13)
   ) dut_i (
      .clk         (clk),
      .rst         (rst),
      .Addr        (Addr),
      .DataIn      (DataIn),
      .Rd          (Rd),
      .Wr          (Wr),
      .DataOut     (DataOut),
      .Done        (Done),
      .Stall       (Stall),
      .cacheHitOut (cacheHitOut),
      .err         (err)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   // ##################################################
   // Watchdog
   // ##################################################
   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= maxCycles) begin
         $display("Run stopped after %0d cycles without finishing", cycleCount);
         $display("Some tests failed");
         $finish;
      end
   end

   // ##################################################
   // Checks
   // ##################################################
   task automatic checkValue(input string name, input wordT expVal, input wordT actVal);
      assert (actVal === expVal) else begin
         errors++;
         $display("FAILED at %0d ns: %s expected %h actual %h", $time, name, expVal, actVal);
      end
   endtask

   task automatic checkBit(input string name, input logic expVal, input logic actVal);
      assert (actVal === expVal) else begin
         errors++;
         $display("FAILED at %0d ns: %s expected %b actual %b", $time, name, expVal, actVal);
      end
   endtask

   // Nothing in flight
   task automatic checkIdle();
      checkBit("Done", 1'b0, Done);
      checkBit("Stall", 1'b0, Stall);
      checkBit("err", 1'b0, err);
   endtask

   // Pool of 4 indices x 4 tags, so lines keep colliding
   function automatic addrT pickAddr(input logic [31:0] r);
      logic [indexW-1:0] idx;
      logic [tagW-1:0]   tag;
      case (r[5:4])
         2'd0:    idx = 8'h03;
         2'd1:    idx = 8'h5a;
         2'd2:    idx = 8'ha7;
         default: idx = 8'hff;
      endcase
      case (r[7:6])
         2'd0:    tag = 5'h00;
         2'd1:    tag = 5'h01;
         2'd2:    tag = 5'h0a;
         default: tag = 5'h1f;
      endcase
      return {tag, idx, r[9:8], 1'b0};
   endfunction

   // One-cycle request, then follow it to Done
   task automatic runRequest(input logic rdIn, input logic wrIn, input addrT addrIn,
                             input wordT dataIn);
      logic [indexW-1:0]    idx;
      logic [tagW-1:0]      tag;
      logic [wordAddrW-1:0] wAddr;
      logic                 bad;
      logic                 expHit;
      wordT                 expData;
      logic                 gotDone;
      int                   waited;
      idx     = addrIn[offsetW +: indexW];
      tag     = addrIn[offsetW+indexW +: tagW];
      wAddr   = addrIn[15:1];
      bad     = addrIn[0] || (rdIn && wrIn);
      expHit  = modelValid[idx] && (modelTag[idx] == tag);
      expData = shadow[wAddr];

      @(posedge clk);
      #1;
      Addr   = addrIn;
      DataIn = dataIn;
      Rd     = rdIn;
      Wr     = wrIn;
      // Acceptance cycle
      @(negedge clk);
      checkIdle();
      @(posedge clk);
      #1;
      Rd     = 1'b0;
      Wr     = 1'b0;
      // Junk on the bus so only the latched request counts
      Addr   = ~addrIn;
      DataIn = ~dataIn;

      gotDone = 1'b0;
      waited  = 0;
      while (!gotDone && waited < doneBound) begin
         @(negedge clk);
         waited++;
         checkBit("Stall", 1'b1, Stall);
         if (Done) begin
            gotDone = 1'b1;
         end
      end

      assert (gotDone) else begin
         errors++;
         $display("Request to address %h got no Done within %0d cycles", addrIn, doneBound);
      end

      if (gotDone) begin
         checkBit("err", bad, err);
         if (!bad) begin
            checkBit("cacheHitOut", expHit, cacheHitOut);
            if (rdIn) begin
               checkValue("DataOut", expData, DataOut);
            end
         end
      end

      // Model update, write allocate
      if (bad) begin
         badReqs++;
      end else begin
         if (expHit) begin
            hits++;
            modelDirty[idx] = modelDirty[idx] || wrIn;
         end else begin
            misses++;
            if (modelValid[idx] && modelDirty[idx]) begin
               evictions++;
            end
            modelValid[idx] = 1'b1;
            modelTag[idx]   = tag;
            modelDirty[idx] = wrIn;
         end
         if (wrIn) begin
            shadow[wAddr] = dataIn;
         end
      end
   endtask

   // ##################################################
   // Stimulus
   // ##################################################
   initial begin
      logic [31:0] r;
      logic [31:0] d;
      addrT        a;
      clk        = 1'b0;
      rst        = 1'b1;
      Addr       = '0;
      DataIn     = '0;
      Rd         = 1'b0;
      Wr         = 1'b0;
      seed       = 32'h3cc92aba;
      errors     = 0;
      cycleCount = 0;
      hits       = 0;
      misses     = 0;
      evictions  = 0;
      badReqs    = 0;
      for (int i = 0; i < 2**wordAddrW; i++) begin
         shadow[i] = '0;
      end
      for (int i = 0; i < 2**indexW; i++) begin
         modelTag[i]   = '0;
         modelValid[i] = 1'b0;
         modelDirty[i] = 1'b0;
      end

      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      // Quiet outputs before the first request
      repeat (4) begin
         @(negedge clk);
         checkIdle();
      end

      for (int n = 0; n < numReqs; n++) begin
         r = $random(seed);
         d = $random(seed);
         a = pickAddr(r);
         case (r[3:0])
            // Odd address, read or write
            4'd0:    runRequest(!r[12], r[12], a | 16'h0001, d[15:0]);
            // Both strobes
            4'd1:    runRequest(1'b1, 1'b1, a, d[15:0]);
            4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8:
                     runRequest(1'b1, 1'b0, a, d[15:0]);
            default: runRequest(1'b0, 1'b1, a, d[15:0]);
         endcase
         // Occasional idle gap
         if (r[11:10] == 2'b11) begin
            repeat (2) begin
               @(negedge clk);
               checkIdle();
            end
         end
      end

      repeat (2) begin
         @(negedge clk);
         checkIdle();
      end

      $display("Requests %0d, hits %0d, misses %0d, evictions %0d, rejected %0d, errors %0d",
               numReqs, hits, misses, evictions, badReqs, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- src.f
hdl/memSysPkg.sv
hdl/syncRam.sv
hdl/cacheStore.sv
hdl/fourBankMem.sv
hdl/cacheCtrl.sv
hdl/memSystem.sv
dv/memSystemTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the memory system testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert -Wno-fatal --timescale 1ns/10ps \
   --top-module memSystemTb -f src.f --Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
